/* sources.f */
src/adxl_logger_pkg.sv
src/sync_gen.sv
src/adxl_reader.sv
src/host_spi_slave.sv
src/sample_buffer.sv
src/adxl_logger_top.sv
verif/adxl_logger_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the adxl logger testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module adxl_logger_tb -Mdir obj_dir -o Vadxl_logger_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vadxl_logger_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* verif/adxl_logger_tb.sv */
/*
  adxl logger testbench
  sensor spi model, pps source, host spi tasks and a step table covering
  reset state, frames, pointer and buffer reads, direct mode and lock
*/
`timescale 1ns/100ps
module adxl_logger_tb;

  typedef enum logic [3:0] {K_RESET, K_READ, K_WRITE, K_FRAMES, K_PTR, K_BUF, K_DIRECT,
                            K_LOCK} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic [31:0] addr;
    logic [7:0]  wdata;   // write data or a count for frame and buffer steps
    logic [7:0]  exp;
  } step_t;

  localparam int NSTEPS = 12;

  logic clk = 1'b0;
  logic rst_n;
  logic pps = 1'b0;
  logic host_csn;
  logic host_sclk;
  logic host_mosi;
  logic host_miso;
  logic adxl_csn;
  logic adxl_sclk;
  logic adxl_mosi;
  logic adxl_miso = 1'b0;
  logic drdy;
  logic pps_valid;
  logic locked;

  step_t steps [NSTEPS];
  int errors = 0;
  int model_errors = 0;     // owned by the sensor model
  int frame_cnt = 0;        // complete reader frames seen by the model
  logic direct_flag = 1'b0; // host owns the sensor bus so frame checks are skipped
  logic last_csn = 1'b1;
  logic [7:0] m_cmd = 8'h00;
  int m_bits = 0;
  int m_byte;
  logic [7:0] m_tx;
  int pps_cnt = 0;
  int lock_at = -1;         // pps intervals elapsed when locked was first seen
  logic valid_seen = 1'b0;

  always #50 clk = ~clk;    // 100 ns

  adxl_logger_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pps       (pps),
    .host_csn  (host_csn),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_miso (host_miso),
    .adxl_csn  (adxl_csn),
    .adxl_sclk (adxl_sclk),
    .adxl_mosi (adxl_mosi),
    .adxl_miso (adxl_miso),
    .drdy      (drdy),
    .pps_valid (pps_valid),
    .locked    (locked)
  );

  // sensor model samples mosi on sclk rising edges
  always @(posedge adxl_sclk or posedge adxl_csn or negedge adxl_csn)
  begin
    if (adxl_csn && !last_csn)
    begin
      if (!direct_flag)
      begin
        if (m_cmd != 8'h11 || m_bits != 80)
        begin
          $display("Mismatch at %0t: sensor frame cmd %h bits %0d, expected 11 and 80",
                   $time, m_cmd, m_bits);
          model_errors++;
        end
      end
      if (m_cmd == 8'h11 && m_bits == 80)
        frame_cnt++;
    end
    else if (!adxl_csn && last_csn)
    begin
      m_bits = 0;           // new csn low period
      m_cmd = 8'h00;
    end
    else if (!adxl_csn)
    begin
      if (m_bits < 8)
        m_cmd = {m_cmd[6:0], adxl_mosi};
      m_bits++;
    end
    last_csn = adxl_csn;
  end

  // miso changes on sclk falling edges msb first
  always @(negedge adxl_sclk)
  begin
    if (!adxl_csn)
    begin
      m_byte = m_bits / 8;
      if (m_byte == 0)
        m_tx = 8'h00;       // command byte
      else if (m_cmd == 8'h01)
        m_tx = 8'hAD;
      else
        m_tx = 8'((16 * frame_cnt + m_byte - 1) % 256);
      adxl_miso <= m_tx[3'(7 - m_bits % 8)];
    end
  end

  // pps pulse every PPS_CLKS clocks and a note of when lock shows up
  initial
  begin
    repeat (5) @(posedge clk);
    forever
    begin
      for (int c = 0; c < adxl_logger_pkg::PPS_CLKS; c++)
      begin
        @(posedge clk);
        pps <= (c < 5);
        if (locked && lock_at < 0)
          lock_at = pps_cnt;
        if (pps_valid)
          valid_seen = 1'b1;
      end
      pps_cnt++;
    end
  end

  initial
  begin
    repeat (200000) @(posedge clk);
    $display("Simulation stopped by the global timeout");
    $display("Done: errors found");
    $finish;
  end

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic timed_out(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic host_begin();
    @(posedge clk);
    host_csn <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic host_end();
    @(posedge clk);
    host_csn <= 1'b1;
    host_mosi <= 1'b0;
    repeat (8) @(posedge clk);
  endtask

  // one byte with 6 clk low and 6 clk high per bit and miso taken at the rising edge
  task automatic host_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] r;
    r = 8'h00;
    for (int b = 7; b >= 0; b--)
    begin
      @(posedge clk);
      host_sclk <= 1'b0;
      host_mosi <= tx[b];
      repeat (6) @(posedge clk);
      host_sclk <= 1'b1;
      r = {r[6:0], host_miso};
      repeat (5) @(posedge clk);
    end
    rx = r;
  endtask

  task automatic host_header(input logic [7:0] cmd, input logic [31:0] addr);
    logic [7:0] d;
    host_byte(cmd, d);
    for (int i = 3; i >= 0; i--)
      host_byte(addr[i*8 +: 8], d);   // big endian
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [7:0] data);
    host_begin();
    host_header(8'h01, addr);
    host_byte(8'h00, data);
    host_end();
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [7:0] data);
    logic [7:0] d;
    host_begin();
    host_header(8'h00, addr);
    host_byte(data, d);
    host_end();
  endtask

  // byte p of the kept sequence from frame p/6 and sensor bytes 0 1 3 4 6 7
  function automatic logic [7:0] kept_byte(input int p);
    int j;
    j = p % 6;
    return 8'((16 * (p / 6) + j + j / 2) % 256);
  endfunction

  task automatic check_ptr(input logic [31:0] addr);
    logic [7:0] lo;
    logic [7:0] hi;
    logic prev;
    int t;
    int expv;
    prev = 1'b1;
    t = 0;
    while (!(adxl_csn && !prev) && t < 1000)   // end of a frame
    begin
      prev = adxl_csn;
      @(posedge clk);
      t++;
    end
    if (t >= 1000)
      timed_out("no frame end before the pointer read");
    repeat (152) @(posedge clk);   // pointer latch then lands in the gap after a frame
    host_begin();
    host_header(8'h01, addr);
    expv = 6 * frame_cnt;
    host_byte(8'h00, lo);
    host_byte(8'h00, hi);
    host_end();
    if (lo != 8'(expv % 256) || hi != 8'(expv / 256))
      mismatch($sformatf("pointer %h%h, expected %0d", hi, lo, expv));
  endtask

  task automatic check_buf(input int n);
    int avail;
    int i;
    logic [7:0] d;
    avail = 6 * frame_cnt;
    for (int k = 0; k < n; k++)
    begin
      i = int'($urandom % avail);
      host_read({8'h00, 24'(i)}, d);
      if (d != kept_byte(i ^ 1))   // words stored with address bit 0 flipped
        mismatch($sformatf("buffer[%0d] = %h, expected %h", i, d, kept_byte(i ^ 1)));
    end
  endtask

  task automatic wait_frames(input int n);
    int start;
    int t;
    direct_flag = 1'b0;
    start = frame_cnt;
    t = 0;
    while (frame_cnt < start + n && t < 300 * n + 500)
    begin
      @(posedge clk);
      t++;
    end
    if (frame_cnt < start + n)
      timed_out($sformatf("only %0d of %0d frames", frame_cnt - start, n));
  endtask

  task automatic check_direct(input logic [7:0] cmd, input logic [7:0] exp);
    logic [7:0] d;
    int t;
    t = 0;
    while (!dut.direct_en && t < 500)
    begin
      @(posedge clk);
      t++;
    end
    if (!dut.direct_en)
      timed_out("direct mode never granted");
    host_begin();
    host_byte(cmd, d);
    host_byte(8'h00, d);
    host_end();
    if (d != exp)
      mismatch($sformatf("direct read %h, expected %h", d, exp));
  endtask

  task automatic check_lock();
    int t;
    int cnt;
    logic prev;
    logic dq;
    t = 0;
    while (!locked && t < 10 * adxl_logger_pkg::PPS_CLKS)
    begin
      @(posedge clk);
      t++;
    end
    if (!locked)
      timed_out("locked never set");
    if (!valid_seen)
      $display("pps_valid never went high");
    if (!valid_seen)
      errors++;
    if (lock_at < 0 || lock_at > 8)
      mismatch($sformatf("lock after %0d pps intervals, expected at most 8", lock_at));
    prev = 1'b1;
    t = 0;
    while (!(pps && !prev) && t < 1100)   // align to a pps rising edge
    begin
      prev = pps;
      @(posedge clk);
      t++;
    end
    if (t >= 1100)
      timed_out("no pps edge");
    dq = drdy;
    for (int k = 0; k < 3; k++)
    begin
      cnt = 0;
      for (int c = 0; c < adxl_logger_pkg::PPS_CLKS; c++)
      begin
        @(posedge clk);
        if (drdy && !dq)
          cnt++;
        dq = drdy;
      end
      if (cnt != adxl_logger_pkg::SYNCS_PER_PPS)
        mismatch($sformatf("%0d drdy edges in pps interval %0d, expected 10", cnt, k));
    end
  endtask

  initial
  begin
    int tests;
    int failed;
    int e0;
    logic [7:0] d;
    void'($urandom(32'h50cc));
    tests = 0;
    failed = 0;
    rst_n = 1'b0;
    host_csn = 1'b1;
    host_sclk = 1'b1;   // mode 3 idle
    host_mosi = 1'b0;

    steps[0] = '{K_RESET, 32'h0, 8'h00, 8'h00};
    steps[1] = '{K_READ, 32'hFF00_0000, 8'h00, 8'h00};
    steps[2] = '{K_FRAMES, 32'h0, 8'd4, 8'h00};
    steps[3] = '{K_PTR, 32'h0100_0000, 8'h00, 8'h00};
    steps[4] = '{K_BUF, 32'h0, 8'd6, 8'h00};
    steps[5] = '{K_WRITE, 32'hFF00_0000, 8'h02, 8'h00};
    steps[6] = '{K_DIRECT, 32'h0, 8'h01, 8'hAD};
    steps[7] = '{K_WRITE, 32'hFF00_0000, 8'h00, 8'h00};
    steps[8] = '{K_FRAMES, 32'h0, 8'd3, 8'h00};
    steps[9] = '{K_PTR, 32'h0100_0000, 8'h00, 8'h00};
    steps[10] = '{K_BUF, 32'h0, 8'd4, 8'h00};
    steps[11] = '{K_LOCK, 32'h0, 8'h00, 8'h00};

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int s = 0; s < NSTEPS; s++)
    begin
      e0 = errors + model_errors;
      case (steps[s].kind)
        K_RESET:
          if (!adxl_csn || !adxl_sclk || drdy || pps_valid || locked)
            mismatch($sformatf("after reset csn %b sclk %b drdy %b valid %b locked %b",
                               adxl_csn, adxl_sclk, drdy, pps_valid, locked));
        K_READ:
        begin
          host_read(steps[s].addr, d);
          if (d != steps[s].exp)
            mismatch($sformatf("read %h = %h, expected %h", steps[s].addr, d, steps[s].exp));
        end
        K_WRITE:
        begin
          if (steps[s].wdata[1])
            direct_flag = 1'b1;   // bus handover follows this write
          host_write(steps[s].addr, steps[s].wdata);
        end
        K_FRAMES: wait_frames(int'(steps[s].wdata));
        K_PTR: check_ptr(steps[s].addr);
        K_BUF: check_buf(int'(steps[s].wdata));
        K_DIRECT: check_direct(steps[s].wdata, steps[s].exp);
        default: check_lock();
      endcase
      tests++;
      if (errors + model_errors != e0)
      begin
        failed++;
        $display("test %0d %s failed", s, steps[s].kind.name());
      end
      else
        $display("test %0d %s ok", s, steps[s].kind.name());
    end

    $display("tests %0d, failed %0d, errors %0d, frames %0d", tests, failed,
             errors + model_errors, frame_cnt);
    if (errors + model_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* src/adxl_logger_top.sv */
/*
  adxl logger top
  sync generator, sensor reader, host spi slave and sample buffer, plus
  the pin mux that gives the sensor bus to the host in direct mode
*/
`timescale 1ns/100ps
module adxl_logger_top (
  input  logic clk,
  input  logic rst_n,
  input  logic pps,
  input  logic host_csn,
  input  logic host_sclk,
  input  logic host_mosi,
  output logic host_miso,
  output logic adxl_csn,
  output logic adxl_sclk,
  output logic adxl_mosi,
  input  logic adxl_miso,
  output logic drdy,
  output logic pps_valid,
  output logic locked
);

  adxl_logger_pkg::sync_status_t status;
  adxl_logger_pkg::sample_wr_t sample;
  adxl_logger_pkg::host_req_t req;
  adxl_logger_pkg::byte_t rdata;
  logic direct_req;
  logic direct_en;
  logic rd_csn;           // reader side of the sensor bus
  logic rd_sclk;
  logic rd_mosi;
  logic slave_miso;

  sync_gen u_sync_gen (
    .clk    (clk),
    .rst_n  (rst_n),
    .pps    (pps),
    .status (status)
  );

  adxl_reader u_adxl_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .drdy       (status.drdy),
    .direct_req (direct_req),
    .direct_en  (direct_en),
    .adxl_csn   (rd_csn),
    .adxl_sclk  (rd_sclk),
    .adxl_mosi  (rd_mosi),
    .adxl_miso  (adxl_miso),
    .sample     (sample)
  );

  // keeps decoding in direct mode so the host can write ctrl back to 0
  host_spi_slave u_host_spi_slave (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_csn  (host_csn),
    .host_sclk (host_sclk),
    .host_mosi (host_mosi),
    .host_miso (slave_miso),
    .rdata     (rdata),
    .req       (req)
  );

  sample_buffer u_sample_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .sample     (sample),
    .req        (req),
    .rdata      (rdata),
    .direct_req (direct_req)
  );

  // sensor bus owner follows direct_en only
  assign adxl_csn = direct_en ? host_csn : rd_csn;
  assign adxl_sclk = direct_en ? host_sclk : rd_sclk;
  assign adxl_mosi = direct_en ? host_mosi : rd_mosi;
  assign host_miso = direct_en ? adxl_miso : slave_miso;

  assign drdy = status.drdy;          // also the sensor sync pin
  assign pps_valid = status.pps_valid;
  assign locked = status.locked;

endmodule

/* src/sample_buffer.sv */
/*
  sample buffer
  circular byte ram filled by the reader, host read decode for the
  buffer, the latched write pointer and the control byte
*/
`timescale 1ns/100ps
module sample_buffer (
  input  logic clk,
  input  logic rst_n,
  input  adxl_logger_pkg::sample_wr_t sample,
  input  adxl_logger_pkg::host_req_t req,
  output adxl_logger_pkg::byte_t rdata,
  output logic direct_req
);

  adxl_logger_pkg::byte_t ram [adxl_logger_pkg::BUF_LEN];
  adxl_logger_pkg::buf_addr_t wr_ptr;      // next byte slot
  adxl_logger_pkg::buf_addr_t ptr_latch;   // snapshot for the pointer pair
  adxl_logger_pkg::buf_addr_t offset;
  adxl_logger_pkg::byte_t ctrl;            // [1] direct mode, rest reserved
  adxl_logger_pkg::byte_t rdata_q;
  adxl_logger_pkg::host_region_e region;

  assign region = adxl_logger_pkg::host_region_e'(req.addr[31:24]);
  assign offset = req.addr[adxl_logger_pkg::BUF_AW-1:0];

  // write pointer and control register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      ctrl <= '0;
    end
    else
    begin
      if (sample.wr)
      begin
        if (wr_ptr == adxl_logger_pkg::buf_addr_t'(adxl_logger_pkg::BUF_LEN - 1))
          wr_ptr <= '0;                    // wrap
        else
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (req.wr && (region == adxl_logger_pkg::REG_CTRL))
        ctrl <= req.wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    // bit 0 flipped, so each axis word reads back little endian
    if (sample.wr)
      ram[wr_ptr ^ adxl_logger_pkg::buf_addr_t'(1)] <= sample.data;
    if (req.rd)
    begin
      case (region)
        adxl_logger_pkg::REG_BUF:
          if (offset < adxl_logger_pkg::BUF_LEN)
            rdata_q <= ram[offset];
          else
            rdata_q <= '0;                 // hole above the buffer
        adxl_logger_pkg::REG_PTR:
          if (!offset[0])
          begin
            ptr_latch <= wr_ptr;           // even offset snapshots the pointer
            rdata_q <= wr_ptr[7:0];
          end
          else
            rdata_q <= adxl_logger_pkg::byte_t'(ptr_latch[adxl_logger_pkg::BUF_AW-1:8]);
        default: rdata_q <= '0;            // ctrl and unknown regions
      endcase
    end
  end

  assign rdata = rdata_q;          // holds until the next rd
  assign direct_req = ctrl[1];

endmodule

/* src/host_spi_slave.sv */
/*
  host spi slave
  oversampled mode 3 slave, decodes command and 32-bit address and turns
  each data byte into a byte read or write strobe
*/
`timescale 1ns/100ps
module host_spi_slave (
  input  logic clk,
  input  logic rst_n,
  input  logic host_csn,
  input  logic host_sclk,
  input  logic host_mosi,
  output logic host_miso,
  input  adxl_logger_pkg::byte_t rdata,
  output adxl_logger_pkg::host_req_t req
);

  logic [1:0] csn_r;
  logic [2:0] sclk_r;                // two sync flops + previous
  logic [1:0] mosi_r;
  logic csn_s;
  logic mosi_s;
  logic sclk_rise;
  logic sclk_fall;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt;              // 0 cmd, 1..4 addr, 5 data (sticks)
  logic byte_done;
  adxl_logger_pkg::host_cmd_e cmd;
  adxl_logger_pkg::host_addr_t addr;     // running address
  adxl_logger_pkg::host_addr_t addr_q;   // address carried with the strobe
  adxl_logger_pkg::byte_t shift_in;
  adxl_logger_pkg::byte_t shift_out;
  adxl_logger_pkg::byte_t rx_byte;
  adxl_logger_pkg::byte_t wdata_q;
  logic rd_q;
  logic wr_q;
  logic miso_q;

  assign csn_s = csn_r[1];
  assign mosi_s = mosi_r[1];
  assign sclk_rise = sclk_r[1] & ~sclk_r[2];
  assign sclk_fall = ~sclk_r[1] & sclk_r[2];
  assign rx_byte = {shift_in[6:0], mosi_s};
  assign byte_done = sclk_rise && !csn_s && (bit_cnt == 3'd7);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      csn_r <= '1;
      sclk_r <= '1;
      mosi_r <= '0;
      bit_cnt <= '0;
      byte_cnt <= '0;
      cmd <= adxl_logger_pkg::CMD_WRITE;
      rd_q <= 1'b0;
      wr_q <= 1'b0;
      miso_q <= 1'b0;
    end
    else
    begin
      csn_r <= {csn_r[0], host_csn};
      sclk_r <= {sclk_r[1:0], host_sclk};
      mosi_r <= {mosi_r[0], host_mosi};
      rd_q <= 1'b0;
      wr_q <= 1'b0;
      if (csn_s)
      begin
        bit_cnt <= '0;   // abort, next transfer starts with a command
        byte_cnt <= '0;
      end
      else if (sclk_rise)
      begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
        begin
          if (byte_cnt != 3'd5)
            byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'd0)
            cmd <= adxl_logger_pkg::host_cmd_e'(rx_byte);
          else if (byte_cnt == 3'd4)
            rd_q <= (cmd == adxl_logger_pkg::CMD_READ);   // first read byte
          else if (byte_cnt == 3'd5)
          begin
            rd_q <= (cmd == adxl_logger_pkg::CMD_READ);   // fetch ahead
            wr_q <= (cmd == adxl_logger_pkg::CMD_WRITE);
          end
        end
      end
      // msb first on falling edges, a new byte loads at bit 0
      if (sclk_fall && !csn_s)
        miso_q <= (bit_cnt == 3'd0) ? rdata[7] : shift_out[7];
    end
  end

  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_in <= rx_byte;
    if (sclk_fall)
      shift_out <= (bit_cnt == 3'd0) ? {rdata[6:0], 1'b0} : {shift_out[6:0], 1'b0};
    if (byte_done)
    begin
      if (byte_cnt inside {[3'd1:3'd4]})
      begin
        addr <= {addr[23:0], rx_byte};     // big endian
        addr_q <= {addr[23:0], rx_byte};
      end
      else if (byte_cnt == 3'd5)
      begin
        addr <= addr + 32'd1;
        // write lands at the current address, read prefetches the next one
        addr_q <= (cmd == adxl_logger_pkg::CMD_WRITE) ? addr : addr + 32'd1;
        wdata_q <= rx_byte;
      end
    end
  end

  assign req = '{rd: rd_q, wr: wr_q, addr: addr_q, wdata: wdata_q};
  assign host_miso = miso_q;

endmodule

/* src/adxl_reader.sv */
/*
  adxl frame reader
  spi mode 3 master, one xyz frame per drdy edge, keeps the upper 16 bits
  of each axis and hands the sensor pins to the host when idle
*/
`timescale 1ns/100ps
module adxl_reader (
  input  logic clk,
  input  logic rst_n,
  input  logic drdy,
  input  logic direct_req,
  output logic direct_en,
  output logic adxl_csn,
  output logic adxl_sclk,
  output logic adxl_mosi,
  input  logic adxl_miso,
  output adxl_logger_pkg::sample_wr_t sample
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,    // shifting out the read command
    ST_DATA,   // clocking in the frame
    ST_DONE
  } state_e;

  state_e state;
  logic drdy_q;
  logic start;                       // registered drdy rising edge
  logic active;
  logic [3:0] clk_cnt;               // 2 clk per bit, 16 per byte
  logic [3:0] byte_cnt;              // 0 = command, 1..9 = data
  logic byte_end;
  logic keep;
  adxl_logger_pkg::byte_t shift_out;
  adxl_logger_pkg::byte_t shift_in;
  adxl_logger_pkg::byte_t rx_byte;
  adxl_logger_pkg::byte_t wr_data;
  logic wr_q;

  assign active = (state == ST_CMD) || (state == ST_DATA);
  assign byte_end = active && (clk_cnt == 4'd15);
  assign rx_byte = {shift_in[6:0], adxl_miso};   // includes the bit sampled now

  // every third data byte holds the low nibble of an axis, skip it
  assign keep = (byte_cnt != 4'd3) && (byte_cnt != 4'd6) && (byte_cnt != 4'd9);

  // pins go to the host only between frames
  assign direct_en = (state == ST_IDLE) && direct_req;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      drdy_q <= 1'b0;
      start <= 1'b0;
      clk_cnt <= '0;
      byte_cnt <= '0;
      adxl_csn <= 1'b1;
      adxl_sclk <= 1'b1;   // mode 3 idles high
      adxl_mosi <= 1'b0;
      wr_q <= 1'b0;
    end
    else
    begin
      drdy_q <= drdy;
      start <= drdy & ~drdy_q;
      wr_q <= byte_end && (state == ST_DATA) && keep;
      case (state)
        ST_IDLE:
          if (start && !direct_req)   // edges during a frame are dropped
          begin
            state <= ST_CMD;
            adxl_csn <= 1'b0;
            clk_cnt <= '0;
            byte_cnt <= '0;
          end
        ST_CMD, ST_DATA:
        begin
          clk_cnt <= clk_cnt + 4'd1;
          if (!clk_cnt[0])
          begin
            adxl_sclk <= 1'b0;               // falling edge, next bit out
            adxl_mosi <= shift_out[7];
          end
          else
            adxl_sclk <= 1'b1;               // rising edge, miso sampled
          if (byte_end)
          begin
            byte_cnt <= byte_cnt + 4'd1;
            if (state == ST_CMD)
              state <= ST_DATA;
            else if (byte_cnt == 4'(adxl_logger_pkg::FRAME_LEN))
              state <= ST_DONE;
          end
        end
        ST_DONE:
        begin
          adxl_csn <= 1'b1;   // sclk is already back high
          adxl_mosi <= 1'b0;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // shift registers and sample byte
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE)
      shift_out <= adxl_logger_pkg::READ_CMD;
    else if (active && clk_cnt[0])
    begin
      shift_out <= {shift_out[6:0], 1'b0};   // zeros during data bytes
      shift_in <= rx_byte;
    end
    if (byte_end && (state == ST_DATA))
      wr_data <= rx_byte;
  end

  assign sample = '{wr: wr_q, data: wr_data};

endmodule

/* src/sync_gen.sv */
/*
  sync / drdy generator
  phase accumulator clocking the sensor sample rate, steered by pps
  interval checks until the sync count per interval is exact
*/
`timescale 1ns/100ps
module sync_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic pps,
  output adxl_logger_pkg::sync_status_t status
);

  adxl_logger_pkg::pa_t acc;   // msb is drdy
  adxl_logger_pkg::pa_t inc;   // steered increment
  logic [2:0] pps_r;           // [0] meta, [1] synced, [2] previous
  logic pps_rise;
  logic drdy_q;
  logic drdy_rise;
  logic [$clog2(2 * adxl_logger_pkg::PPS_CLKS)-1:0] clk_cnt;  // saturates
  logic [7:0] sync_cnt;        // drdy edges so far in this interval
  logic [7:0] sync_total;      // including an edge on the pps clock itself
  logic interval_ok;
  logic exact_ok;
  logic prev_exact;            // last interval was valid and exact
  logic pps_valid;
  logic locked;

  assign pps_rise = pps_r[1] & ~pps_r[2];
  assign drdy_rise = acc[adxl_logger_pkg::PA_BITS-1] & ~drdy_q;
  assign sync_total = sync_cnt + {7'd0, drdy_rise};

  // interval length inside the window around the nominal pps period
  assign interval_ok = (clk_cnt >= adxl_logger_pkg::PPS_CLKS - adxl_logger_pkg::PPS_TOL) &&
                       (clk_cnt <= adxl_logger_pkg::PPS_CLKS + adxl_logger_pkg::PPS_TOL);
  assign exact_ok = interval_ok && (sync_total == adxl_logger_pkg::SYNCS_PER_PPS);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc <= '0;
      inc <= adxl_logger_pkg::PA_INC_NOM;
      pps_r <= '0;
      drdy_q <= 1'b0;
      clk_cnt <= '0;
      sync_cnt <= '0;
      prev_exact <= 1'b0;
      pps_valid <= 1'b0;
      locked <= 1'b0;
    end
    else
    begin
      acc <= acc + inc;                 // wraps freely
      pps_r <= {pps_r[1:0], pps};
      drdy_q <= acc[adxl_logger_pkg::PA_BITS-1];
      if (pps_rise)
      begin
        clk_cnt <= 1;                   // this clock starts the next interval
        sync_cnt <= '0;
        pps_valid <= interval_ok;
        // too few syncs -> speed up, too many -> slow down
        if (interval_ok && sync_total < adxl_logger_pkg::SYNCS_PER_PPS)
          inc <= inc + adxl_logger_pkg::PA_STEP;
        else if (interval_ok && sync_total > adxl_logger_pkg::SYNCS_PER_PPS)
          inc <= inc - adxl_logger_pkg::PA_STEP;
        prev_exact <= exact_ok;
        locked <= exact_ok && prev_exact;   // two exact intervals in a row
      end
      else
      begin
        if (clk_cnt != '1)
          clk_cnt <= clk_cnt + 1;       // hold at max when pps is missing
        sync_cnt <= sync_cnt + {7'd0, drdy_rise};
      end
    end
  end

  assign status = '{pps_valid: pps_valid,
                    locked: locked,
                    drdy: acc[adxl_logger_pkg::PA_BITS-1]};

endmodule

/* src/adxl_logger_pkg.sv */
/*
  adxl logger shared definitions
  buffer sizes, sync generator constants, host protocol codes and the
  structs passed between blocks
*/
package adxl_logger_pkg;

  localparam int BUF_LEN = 6144;      // 6 kB circular sample buffer
  localparam int BUF_AW = 13;         // byte address width of the buffer
  localparam int FRAME_LEN = 9;       // 3 axes x 3 data bytes
  localparam int PA_BITS = 30;        // phase accumulator width
  localparam int SYNCS_PER_PPS = 10;  // sync edges expected per pps interval
  localparam int PPS_CLKS = 1000;     // clocks per pps interval
  localparam int PPS_TOL = 50;        // +- clocks accepted on an interval

  typedef logic [7:0] byte_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;
  typedef logic [31:0] host_addr_t;   // top byte is the region
  typedef logic [PA_BITS-1:0] pa_t;

  localparam byte_t READ_CMD = 8'h11;          // (0x08 << 1) | read, xdata3 onwards
  localparam pa_t PA_INC_NOM = 30'd10737418;  // 2^30 / 100 -> sync every 100 clk
  localparam pa_t PA_STEP = 30'd64;           // increment nudge per pps interval

  // host address regions
  typedef enum logic [7:0] {
    REG_BUF  = 8'h00,
    REG_PTR  = 8'h01,
    REG_CTRL = 8'hff
  } host_region_e;

  // first byte of a host transfer
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h00,
    CMD_READ  = 8'h01
  } host_cmd_e;

  typedef struct packed {
    logic       rd;     // one clk, byte address complete
    logic       wr;     // one clk, data byte complete
    host_addr_t addr;
    byte_t      wdata;
  } host_req_t;

  typedef struct packed {
    logic  wr;          // one byte per strobe, never stalled
    byte_t data;
  } sample_wr_t;

  typedef struct packed {
    logic pps_valid;
    logic locked;
    logic drdy;
  } sync_status_t;

endpackage
